// ==== hw/noc_params_pkg.sv ====
package noc_params_pkg;

	// port and buffer sizing
	localparam int NUM_VC     = 4; // virtual channels per port
	localparam int BUF_DEPTH  = 4; // flits per input vc fifo
	localparam int DOWN_DEPTH = 4; // flits per downstream vc buffer
	localparam int NUM_PORTS  = 5;

	// mesh geometry
	localparam int NX = 4;
	localparam int NY = 4;

	localparam int PAYLOAD_W = 32;

	// one coordinate must cover the wider mesh dimension
	localparam int COORD_W = $clog2((NX > NY) ? NX : NY);

	// occupancy counters have to hold the full value, not just depth-1
	localparam int DEPTH_W = $clog2(DOWN_DEPTH + 1);

	// output port indices
	localparam int PORT_LOCAL = 0;
	localparam int PORT_EAST  = 1;
	localparam int PORT_NORTH = 2;
	localparam int PORT_WEST  = 3;
	localparam int PORT_SOUTH = 4;

endpackage

// ==== hw/noc_flit_pkg.sv ====
package noc_flit_pkg;

	import noc_params_pkg::*;

	typedef logic [NUM_VC-1:0]    vc_mask_t;   // one bit per vc
	typedef logic [NUM_PORTS-1:0] port_mask_t; // one-hot output port
	typedef logic [COORD_W-1:0]   coord_t;
	typedef logic [DEPTH_W-1:0]   depth_t;

	// head flits carry dest_x in payload[1:0] and dest_y in payload[3:2]
	typedef struct packed {
		logic                 hdr;
		logic                 tail;
		vc_mask_t             vc;
		logic [PAYLOAD_W-1:0] payload;
	} flit_t;

	// one-cycle grant from the vc allocator, both fields one-hot
	typedef struct packed {
		vc_mask_t ivc;
		vc_mask_t ovc;
	} ovc_grant_t;

	// one-hot port masks
	localparam port_mask_t PMASK_LOCAL = port_mask_t'(1) << PORT_LOCAL;
	localparam port_mask_t PMASK_EAST  = port_mask_t'(1) << PORT_EAST;
	localparam port_mask_t PMASK_NORTH = port_mask_t'(1) << PORT_NORTH;
	localparam port_mask_t PMASK_WEST  = port_mask_t'(1) << PORT_WEST;
	localparam port_mask_t PMASK_SOUTH = port_mask_t'(1) << PORT_SOUTH;

endpackage

// ==== hw/xy_route.sv ====
`timescale 1ns/1ps

module xy_route (
	input  noc_flit_pkg::coord_t     current_x,
	input  noc_flit_pkg::coord_t     current_y,
	input  noc_flit_pkg::coord_t     dest_x,
	input  noc_flit_pkg::coord_t     dest_y,
	output noc_flit_pkg::port_mask_t port
);

	import noc_flit_pkg::*;

	// x first, then y, local only when both match
	always_comb begin
		if (dest_x > current_x) begin
			port = PMASK_EAST;
		end else if (dest_x < current_x) begin
			port = PMASK_WEST;
		end else if (dest_y > current_y) begin
			port = PMASK_NORTH;
		end else if (dest_y < current_y) begin
			port = PMASK_SOUTH;
		end else begin
			port = PMASK_LOCAL; // arrived
		end
	end

endmodule

// ==== hw/ivc_queue.sv ====
`timescale 1ns/1ps

module ivc_queue (
	input  logic                    clk,
	input  logic                    reset,
	input  noc_flit_pkg::flit_t     flit_in,
	input  logic                    flit_in_we,
	input  noc_flit_pkg::vc_mask_t  sw_grant,
	input  noc_flit_pkg::coord_t    current_x,
	input  noc_flit_pkg::coord_t    current_y,
	output noc_flit_pkg::vc_mask_t  not_empty,
	output noc_flit_pkg::vc_mask_t  head_tail,
	output noc_flit_pkg::port_mask_t [noc_params_pkg::NUM_VC-1:0] dest_port,
	output noc_flit_pkg::flit_t     flit_out
);

	import noc_params_pkg::*;
	import noc_flit_pkg::*;

	flit_t [NUM_VC-1:0] head; // flit at the read pointer of each fifo

	genvar v;
	generate
		for (v = 0; v < NUM_VC; v++) begin : g_vc
			flit_t                        mem [BUF_DEPTH];
			logic [$clog2(BUF_DEPTH)-1:0] wr_ptr;
			logic [$clog2(BUF_DEPTH)-1:0] rd_ptr;
			depth_t                       count;
			logic                         push;
			logic                         pop;
			port_mask_t                   head_route;
			port_mask_t                   route_q; // route of the packet in flight

			assign push = flit_in_we & flit_in.vc[v];
			assign pop  = sw_grant[v];

			always_ff @(posedge clk) begin
				if (push) begin
					mem[wr_ptr] <= flit_in;
				end
			end

			// pointers wrap by themselves, depth is a power of two
			always_ff @(posedge clk or posedge reset) begin
				if (reset) begin
					wr_ptr  <= '0;
					rd_ptr  <= '0;
					count   <= '0;
					route_q <= '0;
				end else begin
					if (push) begin
						wr_ptr <= wr_ptr + 1'b1;
					end
					if (pop) begin
						rd_ptr <= rd_ptr + 1'b1;
					end
					count <= count + depth_t'(push) - depth_t'(pop);
					// capture while the head flit sits at the front
					if (not_empty[v] && head[v].hdr) begin
						route_q <= head_route;
					end
				end
			end

			assign head[v]      = mem[rd_ptr];
			assign not_empty[v] = (count != '0);
			assign head_tail[v] = not_empty[v] & head[v].tail;

			xy_route route_i (
				.current_x (current_x),
				.current_y (current_y),
				.dest_x    (head[v].payload[COORD_W-1:0]),
				.dest_y    (head[v].payload[2*COORD_W-1:COORD_W]),
				.port      (head_route)
			);

			// head flit routes itself, body flits use the held route
			assign dest_port[v] = head[v].hdr ? head_route : route_q;
		end
	endgenerate

	// crossbar side, sw_grant is at most one-hot
	always_comb begin
		flit_out = '0;
		for (int i = 0; i < NUM_VC; i++) begin
			if (sw_grant[i]) begin
				flit_out = head[i];
			end
		end
	end

endmodule

// ==== hw/ivc_alloc_state.sv ====
`timescale 1ns/1ps

module ivc_alloc_state (
	input  logic                     clk,
	input  logic                     reset,
	input  noc_flit_pkg::ovc_grant_t ovc_grant,
	input  noc_flit_pkg::vc_mask_t   sw_grant,
	input  noc_flit_pkg::vc_mask_t   not_empty,
	input  noc_flit_pkg::vc_mask_t   head_tail,
	input  noc_flit_pkg::vc_mask_t   ovc_available,
	input  noc_flit_pkg::vc_mask_t   ovc_full,
	output noc_flit_pkg::vc_mask_t   ovc_is_assigned,
	output noc_flit_pkg::vc_mask_t [noc_params_pkg::NUM_VC-1:0] assigned_ovc,
	output noc_flit_pkg::vc_mask_t [noc_params_pkg::NUM_VC-1:0] masked_ovc_request,
	output noc_flit_pkg::vc_mask_t   assigned_ovc_not_full,
	output noc_flit_pkg::vc_mask_t   credit_out
);

	import noc_params_pkg::*;
	import noc_flit_pkg::*;

	vc_mask_t release_ivc;

	assign release_ivc = sw_grant & head_tail; // tail leaving the ivc

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ovc_is_assigned <= '0;
			assigned_ovc    <= '0;
			credit_out      <= '0;
		end else begin
			for (int i = 0; i < NUM_VC; i++) begin
				if (release_ivc[i]) begin
					ovc_is_assigned[i] <= 1'b0;
				end else if (ovc_grant.ivc[i]) begin
					ovc_is_assigned[i] <= 1'b1;
					assigned_ovc[i]    <= ovc_grant.ovc;
				end
			end
			credit_out <= sw_grant; // one slot freed per grant
		end
	end

	always_comb begin
		for (int i = 0; i < NUM_VC; i++) begin
			// only a waiting head asks for an ovc
			masked_ovc_request[i] = (not_empty[i] && !ovc_is_assigned[i]) ? ovc_available : '0;
			assigned_ovc_not_full[i] = ovc_is_assigned[i] & ~|(assigned_ovc[i] & ovc_full);
		end
	end

endmodule

// ==== hw/ovc_status.sv ====
`timescale 1ns/1ps

module ovc_status (
	input  logic                     clk,
	input  logic                     reset,
	input  noc_flit_pkg::vc_mask_t   sw_grant,
	input  noc_flit_pkg::vc_mask_t   head_tail,
	input  noc_flit_pkg::vc_mask_t [noc_params_pkg::NUM_VC-1:0] assigned_ovc,
	input  noc_flit_pkg::ovc_grant_t ovc_grant,
	input  noc_flit_pkg::vc_mask_t   credit_in,
	output noc_flit_pkg::vc_mask_t   ovc_available,
	output noc_flit_pkg::vc_mask_t   ovc_full
);

	import noc_params_pkg::*;
	import noc_flit_pkg::*;

	depth_t [NUM_VC-1:0] depth;     // flits held downstream per ovc
	vc_mask_t            allocated;
	vc_mask_t            ovc_wr;    // ovc written through the crossbar
	vc_mask_t            ovc_tail_wr;
	vc_mask_t            ovc_alloc;

	// map the granted ivc onto its ovc
	always_comb begin
		ovc_wr      = '0;
		ovc_tail_wr = '0;
		for (int i = 0; i < NUM_VC; i++) begin
			if (sw_grant[i]) begin
				ovc_wr = ovc_wr | assigned_ovc[i];
				if (head_tail[i]) begin
					ovc_tail_wr = ovc_tail_wr | assigned_ovc[i];
				end
			end
		end
	end

	assign ovc_alloc = (|ovc_grant.ivc) ? ovc_grant.ovc : '0;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			depth     <= '0;
			allocated <= '0;
		end else begin
			for (int o = 0; o < NUM_VC; o++) begin
				// write and credit together leave the depth as is
				if (ovc_wr[o] && !credit_in[o]) begin
					depth[o] <= depth[o] + 1'b1;
				end else if (!ovc_wr[o] && credit_in[o]) begin
					depth[o] <= depth[o] - 1'b1;
				end
				if (ovc_tail_wr[o]) begin
					allocated[o] <= 1'b0; // packet fully sent
				end else if (ovc_alloc[o]) begin
					allocated[o] <= 1'b1;
				end
			end
		end
	end

	always_comb begin
		for (int o = 0; o < NUM_VC; o++) begin
			ovc_full[o] = (depth[o] == depth_t'(DOWN_DEPTH));
		end
	end

	assign ovc_available = ~allocated & ~ovc_full;

endmodule

// ==== hw/inout_port.sv ====
`timescale 1ns/1ps

module inout_port (
	input  logic                     clk,
	input  logic                     reset,
	input  noc_flit_pkg::coord_t     current_x,
	input  noc_flit_pkg::coord_t     current_y,
	input  noc_flit_pkg::flit_t      flit_in,
	input  logic                     flit_in_we,
	input  noc_flit_pkg::vc_mask_t   credit_in,
	input  noc_flit_pkg::ovc_grant_t ovc_grant,
	input  noc_flit_pkg::vc_mask_t   sw_grant,
	output noc_flit_pkg::vc_mask_t   credit_out,
	output noc_flit_pkg::vc_mask_t   ivc_request,
	output noc_flit_pkg::port_mask_t [noc_params_pkg::NUM_VC-1:0] dest_port,
	output noc_flit_pkg::vc_mask_t   ovc_is_assigned,
	output noc_flit_pkg::vc_mask_t [noc_params_pkg::NUM_VC-1:0] masked_ovc_request,
	output noc_flit_pkg::vc_mask_t   assigned_ovc_not_full,
	output noc_flit_pkg::flit_t      flit_out
);

	import noc_params_pkg::*;
	import noc_flit_pkg::*;

	vc_mask_t              head_tail;
	vc_mask_t [NUM_VC-1:0] assigned_ovc;
	vc_mask_t              ovc_available;
	vc_mask_t              ovc_full;

	// input side, non-empty fifos are the allocator requests
	ivc_queue ivc_queue_i (
		.clk        (clk),
		.reset      (reset),
		.flit_in    (flit_in),
		.flit_in_we (flit_in_we),
		.sw_grant   (sw_grant),
		.current_x  (current_x),
		.current_y  (current_y),
		.not_empty  (ivc_request),
		.head_tail  (head_tail),
		.dest_port  (dest_port),
		.flit_out   (flit_out)
	);

	ivc_alloc_state ivc_alloc_state_i (
		.clk                   (clk),
		.reset                 (reset),
		.ovc_grant             (ovc_grant),
		.sw_grant              (sw_grant),
		.not_empty             (ivc_request),
		.head_tail             (head_tail),
		.ovc_available         (ovc_available),
		.ovc_full              (ovc_full),
		.ovc_is_assigned       (ovc_is_assigned),
		.assigned_ovc          (assigned_ovc),
		.masked_ovc_request    (masked_ovc_request),
		.assigned_ovc_not_full (assigned_ovc_not_full),
		.credit_out            (credit_out)
	);

	// downstream credit bookkeeping
	ovc_status ovc_status_i (
		.clk           (clk),
		.reset         (reset),
		.sw_grant      (sw_grant),
		.head_tail     (head_tail),
		.assigned_ovc  (assigned_ovc),
		.ovc_grant     (ovc_grant),
		.credit_in     (credit_in),
		.ovc_available (ovc_available),
		.ovc_full      (ovc_full)
	);

endmodule

// ==== verification/tb_port_model.svh ====
`ifndef TB_PORT_MODEL_SVH
`define TB_PORT_MODEL_SVH

flit_t      fifo_q [NUM_VC][$];
port_mask_t route_q [NUM_VC][$]; // route each queued flit has to show
port_mask_t pkt_route [NUM_VC];  // route of the last head written per vc
bit         m_assigned [NUM_VC];
int         m_aovc [NUM_VC];
int         m_depth [NUM_VC];    // flits held downstream per ovc
bit         m_alloc [NUM_VC];
vc_mask_t   m_credit_out;

// dimension order, x is resolved before y
function automatic port_mask_t xy_expect(input int dx, input int dy);
	int p;
	p = PORT_LOCAL;
	if (dx != POS_X)
		p = (dx > POS_X) ? PORT_EAST : PORT_WEST;
	else if (dy != POS_Y)
		p = (dy > POS_Y) ? PORT_NORTH : PORT_SOUTH;
	return port_mask_t'(1 << p);
endfunction

function automatic vc_mask_t exp_not_empty();
	vc_mask_t m;
	for (int v = 0; v < NUM_VC; v++)
		m[v] = (fifo_q[v].size() != 0);
	return m;
endfunction

function automatic vc_mask_t exp_assigned();
	vc_mask_t m;
	for (int v = 0; v < NUM_VC; v++)
		m[v] = m_assigned[v];
	return m;
endfunction

function automatic vc_mask_t exp_available();
	vc_mask_t m;
	for (int o = 0; o < NUM_VC; o++)
		m[o] = !m_alloc[o] && (m_depth[o] != DOWN_DEPTH);
	return m;
endfunction

function automatic vc_mask_t exp_not_full();
	vc_mask_t m;
	for (int v = 0; v < NUM_VC; v++)
		m[v] = m_assigned[v] && (m_depth[m_aovc[v]] != DOWN_DEPTH);
	return m;
endfunction

function automatic vc_mask_t exp_ovc_request(input int v);
	return (fifo_q[v].size() != 0 && !m_assigned[v]) ? exp_available() : '0;
endfunction

function automatic bit any_ovc_full();
	bit full;
	full = 1'b0;
	for (int o = 0; o < NUM_VC; o++)
		full = full || (m_depth[o] == DOWN_DEPTH);
	return full;
endfunction

function automatic bit model_idle();
	bit idle;
	idle = (exp_not_empty() == '0);
	for (int o = 0; o < NUM_VC; o++)
		idle = idle && (m_depth[o] == 0);
	return idle;
endfunction

task automatic model_reset();
	for (int v = 0; v < NUM_VC; v++) begin
		fifo_q[v].delete();
		route_q[v].delete();
		pkt_route[v] = '0;
		m_assigned[v] = 1'b0;
		m_aovc[v] = 0;
		m_depth[v] = 0;
		m_alloc[v] = 1'b0;
	end
	m_credit_out = '0;
endtask

// next state after one clock edge with the given inputs
task automatic model_update(input int sw, input int gi, input int go, input vc_mask_t cred,
		input bit push, input int pv, input flit_t f);
	flit_t g;
	vc_mask_t swm;
	swm = '0;
	if (sw >= 0) begin
		g = fifo_q[sw].pop_front();
		route_q[sw].delete(0);
		m_depth[m_aovc[sw]]++;
		swm[sw] = 1'b1;
		if (g.tail) begin // packet gone, free both sides
			m_assigned[sw] = 1'b0;
			m_alloc[m_aovc[sw]] = 1'b0;
		end
	end
	for (int o = 0; o < NUM_VC; o++)
		if (cred[o])
			m_depth[o]--;
	if (gi >= 0) begin
		m_assigned[gi] = 1'b1;
		m_aovc[gi] = go;
		m_alloc[go] = 1'b1;
	end
	if (push) begin
		if (f.hdr)
			pkt_route[pv] = xy_expect(int'(f.payload[1:0]), int'(f.payload[3:2]));
		fifo_q[pv].push_back(f);
		route_q[pv].push_back(pkt_route[pv]);
	end
	m_credit_out = swm;
endtask

`endif

// ==== verification/tb_inout_port.sv ====
`timescale 1ns/1ps

module tb_inout_port;

	import noc_params_pkg::*;
	import noc_flit_pkg::*;

	localparam int POS_X = 1; // fixed router position in the mesh
	localparam int POS_Y = 2;

	logic                    clk;
	logic                    reset;
	coord_t                  current_x;
	coord_t                  current_y;
	flit_t                   flit_in;
	logic                    flit_in_we;
	vc_mask_t                credit_in;
	ovc_grant_t              ovc_grant;
	vc_mask_t                sw_grant;
	vc_mask_t                credit_out;
	vc_mask_t                ivc_request;
	port_mask_t [NUM_VC-1:0] dest_port;
	vc_mask_t                ovc_is_assigned;
	vc_mask_t [NUM_VC-1:0]   masked_ovc_request;
	vc_mask_t                assigned_ovc_not_full;
	flit_t                   flit_out;

	logic [15:0] lfsr = 16'd4541;
	int          up_cred [NUM_VC]; // free fifo slots as upstream sees them
	int          up_left [NUM_VC]; // flits left in the current packet
	bit          up_head [NUM_VC];
	int          n;

	`include "tb_port_model.svh"

	inout_port inout_port_i (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// x^16 + x^14 + x^13 + x^11 + 1, one step per bit
	function automatic int rand_bits(input int nbits);
		int r;
		logic fb;
		r = 0;
		for (int i = 0; i < nbits; i++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			r = (r << 1) | int'(fb);
		end
		return r;
	endfunction

	// first set bit from a random starting point, -1 if none
	function automatic int pick_random(input vc_mask_t cand);
		int start;
		int v;
		start = rand_bits(2);
		for (int k = 0; k < NUM_VC; k++) begin
			v = (start + k) % NUM_VC;
			if (cand[v])
				return v;
		end
		return -1;
	endfunction

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Something failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_mask(input string name, input vc_mask_t exp, input vc_mask_t act);
		if (exp !== act)
			stop_with_error($sformatf("mismatch %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_port(input string name, input port_mask_t exp, input port_mask_t act);
		if (exp !== act)
			stop_with_error($sformatf("mismatch %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_flit(input string name, input flit_t exp, input flit_t act);
		if (exp !== act)
			stop_with_error($sformatf("mismatch %s expected %h actual %h", name, exp, act));
	endtask

	// everything that only depends on registered state
	task automatic check_state_outputs(input string tag);
		check_mask({tag, " ivc_request"}, exp_not_empty(), ivc_request);
		check_mask({tag, " credit_out"}, m_credit_out, credit_out);
		check_mask({tag, " ovc_is_assigned"}, exp_assigned(), ovc_is_assigned);
		check_mask({tag, " assigned_ovc_not_full"}, exp_not_full(), assigned_ovc_not_full);
		for (int v = 0; v < NUM_VC; v++) begin
			check_mask($sformatf("%s masked_ovc_request[%0d]", tag, v), exp_ovc_request(v),
				masked_ovc_request[v]);
			if (fifo_q[v].size() != 0)
				check_port($sformatf("%s dest_port[%0d]", tag, v), route_q[v][0], dest_port[v]);
		end
	endtask

	task automatic step_cycle(input string tag, input bit inject, input bit give_credit);
		int       sw;
		int       gi;
		int       go;
		int       pv;
		bit       push;
		flit_t    pf;
		vc_mask_t req;
		vc_mask_t cred;
		@(posedge clk);
		#5;
		check_state_outputs(tag);
		// vc allocator, lowest free ovc to one random requester
		go = -1;
		gi = pick_random((exp_available() != '0) ? (exp_not_empty() & ~exp_assigned()) : '0);
		req = (gi >= 0) ? exp_ovc_request(gi) : '0;
		for (int o = NUM_VC - 1; o >= 0; o--)
			if (req[o])
				go = o;
		sw = pick_random(exp_not_empty() & exp_not_full());
		if (rand_bits(2) == 0)
			sw = -1; // idle switch now and then
		// upstream router, one packet at a time per vc
		pv = rand_bits(2);
		if (inject && up_left[pv] == 0) begin
			up_left[pv] = 1 + rand_bits(2) % 3;
			up_head[pv] = 1'b1;
		end
		push = (up_left[pv] > 0) && (up_cred[pv] > 0);
		pf = '0;
		if (push) begin
			pf.hdr = up_head[pv];
			pf.tail = (up_left[pv] == 1);
			pf.vc = vc_mask_t'(1 << pv);
			pf.payload = rand_bits(32);
			up_head[pv] = 1'b0;
			up_left[pv]--;
			up_cred[pv]--;
		end
		cred = '0;
		for (int o = 0; o < NUM_VC; o++)
			if (give_credit && m_depth[o] > 0)
				cred[o] = (rand_bits(1) != 0);
		flit_in = pf;
		flit_in_we = push;
		sw_grant = (sw >= 0) ? vc_mask_t'(1 << sw) : '0;
		ovc_grant.ivc = (gi >= 0) ? vc_mask_t'(1 << gi) : '0;
		ovc_grant.ovc = (go >= 0) ? vc_mask_t'(1 << go) : '0;
		credit_in = cred;
		#1;
		if (sw >= 0) begin
			check_flit({tag, " flit_out"}, fifo_q[sw][0], flit_out);
			up_cred[sw]++; // slot comes back with credit_out
		end
		model_update(sw, gi, go, cred, push, pv, pf);
	endtask

	initial begin
		reset = 1'b1;
		current_x = coord_t'(POS_X);
		current_y = coord_t'(POS_Y);
		flit_in = '0;
		flit_in_we = 1'b0;
		credit_in = '0;
		ovc_grant = '0;
		sw_grant = '0;
		model_reset();
		for (int v = 0; v < NUM_VC; v++) begin
			up_cred[v] = BUF_DEPTH;
			up_left[v] = 0;
			up_head[v] = 1'b0;
		end
		repeat (16) begin
			@(posedge clk);
			#5;
			check_state_outputs("reset");
		end
		reset = 1'b0;
		repeat (600) step_cycle("random", 1'b1, 1'b1);
		// hold credits back until an ovc runs full
		n = 0;
		while (!any_ovc_full()) begin
			if (n == 300)
				stop_with_error("no output vc filled up while credits were held back");
			else begin
				step_cycle("backpressure", 1'b1, 1'b0);
				n++;
			end
		end
		repeat (20) step_cycle("backpressure", 1'b1, 1'b0);
		repeat (200) step_cycle("recovery", 1'b1, 1'b1);
		n = 0;
		while (!model_idle() || up_left[0] + up_left[1] + up_left[2] + up_left[3] != 0) begin
			if (n == 1000)
				stop_with_error("port did not drain before the timeout");
			else begin
				step_cycle("drain", 1'b0, 1'b1);
				n++;
			end
		end
		$display("Everything OK");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+verification
hw/noc_params_pkg.sv
hw/noc_flit_pkg.sv
hw/xy_route.sv
hw/ivc_queue.sv
hw/ivc_alloc_state.sv
hw/ovc_status.sv
hw/inout_port.sv
verification/tb_inout_port.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -j 0 --top-module tb_inout_port -Mdir obj_dir -f src.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi
./obj_dir/Vtb_inout_port
status=$?
if [ $status -ne 0 ]; then
	echo "simulation returned status $status"
	exit $status
fi
exit 0
